// File: sources.f
+incdir+design
design/loader_pkg.sv
design/download_tracker.sv
design/download_packer.sv
design/media_mount_ctrl.sv
design/sdram_write_arbiter.sv
design/psx_loader_top.sv
verification/tb_psx_loader_top.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing
TOP       := tb_psx_loader_top
FILELIST  := sources.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "TB PASSED" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_psx_loader_top.sv
/*
 * Loader testbench
 * Directed tests for downloads, media mounts, memory-card commands
 * and core write sharing, with a back-pressuring RAM model
 */
`include "loader_consts.svh"

module tb_psx_loader_top import loader_pkg::*; ();

	localparam int TIMEOUT = 200;

	logic          clk_1x;
	logic          rst_n;
	host_dl_t      host;
	logic          user_reset;
	logic [2:0]    img_mounted;
	img_size_t     img_size;
	logic          card_load_req;
	logic          card_save_req;
	logic          osd_open;
	logic          autosave_en;
	ram_wr_req_t   core_wr_req;
	logic          core_wr_valid;
	logic          core_wr_ready;
	ram_wr_req_t   ram_wr_req;
	logic          ram_wr_valid;
	logic          ram_wr_ready;
	logic          host_wait;
	media_status_t media;
	card_cmd_t     card_cmd;
	logic          core_hold;
	logic          exe_start;

	logic          bp_on;
	logic          ready_bit;
	logic [31:0]   ready_state = 32'd90;
	logic [31:0]   data_state;
	ram_wr_req_t   ram_log[$];
	media_status_t media_exp;
	string         test_name;
	int            errors;
	int            errors_at_start;
	int            tests_run;
	int            tests_failed;

	psx_loader_top u_dut (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.host          (host),
		.user_reset    (user_reset),
		.img_mounted   (img_mounted),
		.img_size      (img_size),
		.card_load_req (card_load_req),
		.card_save_req (card_save_req),
		.osd_open      (osd_open),
		.autosave_en   (autosave_en),
		.core_wr_req   (core_wr_req),
		.core_wr_valid (core_wr_valid),
		.core_wr_ready (core_wr_ready),
		.ram_wr_req    (ram_wr_req),
		.ram_wr_valid  (ram_wr_valid),
		.ram_wr_ready  (ram_wr_ready),
		.host_wait     (host_wait),
		.media         (media),
		.card_cmd      (card_cmd),
		.core_hold     (core_hold),
		.exe_start     (exe_start)
	);

	always #20 clk_1x = ~clk_1x;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// ========================================
	// RAM model
	// ========================================
	always @(negedge clk_1x) begin
		ready_state = lcg_next(ready_state);
		ready_bit <= ready_state[20];
	end

	// Always ready unless back-pressure is switched on
	assign ram_wr_ready = !bp_on || ready_bit;

	always @(posedge clk_1x) begin
		if (ram_wr_valid && ram_wr_ready)
			ram_log.push_back(ram_wr_req);
	end

	// ========================================
	// Compare tasks
	// ========================================
	task automatic check_req(input string what, input ram_wr_req_t exp, input ram_wr_req_t act);
		if (exp !== act) begin
			$display("** Error [%s] %s: expected addr %h data %h be %h, actual addr %h data %h be %h",
				test_name, what, exp.addr, exp.data, exp.be, act.addr, act.data, act.be);
			errors++;
		end
	endtask

	task automatic check_media(input string what, input media_status_t exp,
		input media_status_t act);
		if (exp !== act) begin
			$display("** Error [%s] %s: expected media %h, actual %h",
				test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_cmd(input string what, input card_cmd_t exp, input card_cmd_t act);
		if (exp !== act) begin
			$display("** Error [%s] %s: expected card_cmd %b, actual %b",
				test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("** Error [%s] %s: expected %b, actual %b", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors == errors_at_start) begin
			$display("%s: pass", test_name);
		end else begin
			tests_failed++;
			$display("%s: fail with %0d errors", test_name, errors - errors_at_start);
		end
	endtask

	// ========================================
	// Bus drivers and waits
	// ========================================
	task automatic wait_host_idle();
		int n;
		n = 0;
		while (host_wait && n < TIMEOUT) begin
			@(negedge clk_1x);
			n++;
		end
		if (host_wait) begin
			$display("[%s] timeout, host_wait never dropped", test_name);
			errors++;
		end
	endtask

	task automatic wait_log(input int count);
		int n;
		n = 0;
		while (ram_log.size() < count && n < TIMEOUT) begin
			@(negedge clk_1x);
			n++;
		end
		if (ram_log.size() < count) begin
			$display("[%s] timeout, the RAM saw only %0d of %0d writes",
				test_name, ram_log.size(), count);
			errors++;
		end
	endtask

	task automatic write_host_word(input ram_addr_t addr, input host_word_t data);
		wait_host_idle();
		host.addr = addr;
		host.data = data;
		host.wr   = 1'b1;
		check_bit("core_hold while loading", 1'b1, core_hold);
		check_bit("exe_start while loading", 1'b0, exe_start);
		@(negedge clk_1x);
		host.wr = 1'b0;
	endtask

	task automatic send_core(input ram_wr_req_t req);
		int   n;
		logic accepted;
		core_wr_req   = req;
		core_wr_valid = 1'b1;
		n        = 0;
		accepted = 1'b0;
		while (!accepted && n < TIMEOUT) begin
			@(posedge clk_1x);
			accepted = core_wr_ready;
			n++;
		end
		@(negedge clk_1x);
		core_wr_valid = 1'b0;
		if (!accepted) begin
			$display("[%s] timeout, a core write was never accepted", test_name);
			errors++;
		end
	endtask

	// Full download of LCG word pairs, then compare the RAM log
	task automatic load_words(input dl_index_t idx, input ram_addr_t base, input int pairs,
		input logic backpressure);
		ram_wr_req_t expected[$];
		ram_wr_req_t r;
		ram_addr_t   a;
		host_word_t  lo;
		host_word_t  hi;
		int          mark;
		int          i;
		mark          = ram_log.size();
		bp_on         = backpressure;
		host.index    = idx;
		host.download = 1'b1;
		repeat (2) @(negedge clk_1x);
		for (i = 0; i < pairs; i++) begin
			a          = ram_addr_t'(4 * i);
			data_state = lcg_next(data_state);
			lo         = data_state[31:16];
			data_state = lcg_next(data_state);
			hi         = data_state[31:16];
			write_host_word(a, lo);
			write_host_word(a | ram_addr_t'(2), hi);
			r.addr = base + a;
			r.data = {hi, lo};
			r.be   = 4'hf;
			expected.push_back(r);
		end
		wait_host_idle();
		wait_log(mark + pairs);
		bp_on = 1'b0;
		for (i = 0; i < pairs && mark + i < ram_log.size(); i++)
			check_req("download write", expected[i], ram_log[mark + i]);
		check_bit("download write count", 1'b1, ram_log.size() == mark + pairs);
	endtask

	// ========================================
	// Directed tests
	// ========================================
	task automatic test_reset_state();
		start_test("reset_state");
		check_bit("exe_start", 1'b0, exe_start);
		check_bit("host_wait", 1'b0, host_wait);
		check_bit("ram_wr_valid", 1'b0, ram_wr_valid);
		check_bit("core_hold", 1'b0, core_hold);
		check_cmd("card_cmd", '0, card_cmd);
		check_media("media", '0, media);
		user_reset = 1'b1;
		@(negedge clk_1x);
		check_bit("core_hold from user_reset", 1'b1, core_hold);
		user_reset = 1'b0;
		@(negedge clk_1x);
		finish_test();
	endtask

	task automatic test_bios();
		start_test("bios_download");
		load_words(`IDX_BIOS, `BIOS_BASE, 8, 1'b1);
		host.download = 1'b0;
		repeat (2) @(negedge clk_1x);
		check_bit("core_hold released", 1'b0, core_hold);
		finish_test();
	endtask

	task automatic test_exe();
		start_test("exe_download");
		load_words(`IDX_EXE, `EXE_BASE, 2, 1'b0);
		host.download = 1'b0;
		@(negedge clk_1x);
		check_bit("exe_start 1 cycle after", 1'b0, exe_start);
		@(negedge clk_1x);
		check_bit("exe_start 2 cycles after", 1'b1, exe_start);
		repeat (4) begin
			@(negedge clk_1x);
			check_bit("exe_start after pulse", 1'b0, exe_start);
		end
		finish_test();
	endtask

	task automatic test_cd();
		ram_addr_t last_addr;
		start_test("cd_handling");
		img_size    = 64'h0000_0001_e345_6789;
		img_mounted = 3'b001;
		@(negedge clk_1x);
		img_mounted          = 3'b000;
		media_exp.has_cd     = 1'b1;
		media_exp.cd_from_sd = 1'b1;
		media_exp.cd_size    = 30'h2345_6789;
		check_media("sd mount", media_exp, media);
		img_size    = '0;
		img_mounted = 3'b001;
		@(negedge clk_1x);
		img_mounted      = 3'b000;
		media_exp.has_cd = 1'b0;
		check_media("empty mount", media_exp, media);
		load_words(dl_index_t'(`IDX_CD), `CD_BASE, 3, 1'b1);
		// Upper half of the last pair
		last_addr     = ram_addr_t'(4 * 2 + 2);
		host.download = 1'b0;
		repeat (3) @(negedge clk_1x);
		media_exp.has_cd     = 1'b1;
		media_exp.cd_from_sd = 1'b0;
		media_exp.cd_size    = cd_size_t'(last_addr);
		check_media("cd download", media_exp, media);
		finish_test();
	endtask

	task automatic test_cards();
		card_cmd_t c;
		start_test("memory_cards");
		img_size    = 64'd128;
		img_mounted = 3'b100;
		@(negedge clk_1x);
		img_mounted             = 3'b000;
		c                       = '0;
		c.card2_load            = 1'b1;
		media_exp.card2_present = 1'b1;
		check_cmd("card 2 mount", c, card_cmd);
		check_media("card 2 mount", media_exp, media);
		@(negedge clk_1x);
		check_cmd("card 2 mount end", '0, card_cmd);

		card_load_req = 1'b1;
		@(negedge clk_1x);
		c            = '0;
		c.card1_load = 1'b1;
		c.card2_load = 1'b1;
		check_cmd("load request", c, card_cmd);
		@(negedge clk_1x);
		check_cmd("load request held", '0, card_cmd);
		card_load_req = 1'b0;
		@(negedge clk_1x);

		autosave_en = 1'b1;
		osd_open    = 1'b1;
		@(negedge clk_1x);
		c      = '0;
		c.save = 1'b1;
		check_cmd("autosave", c, card_cmd);
		@(negedge clk_1x);
		check_cmd("autosave end", '0, card_cmd);
		osd_open = 1'b0;
		@(negedge clk_1x);
		autosave_en = 1'b0;
		osd_open    = 1'b1;
		repeat (2) begin
			@(negedge clk_1x);
			check_cmd("menu without autosave", '0, card_cmd);
		end
		// Enabling autosave with the menu already open is no menu edge
		autosave_en = 1'b1;
		@(negedge clk_1x);
		check_cmd("autosave enabled in open menu", '0, card_cmd);
		autosave_en = 1'b0;
		osd_open    = 1'b0;
		@(negedge clk_1x);
		finish_test();
	endtask

	task automatic test_core_writes();
		ram_wr_req_t expected[$];
		ram_wr_req_t r;
		int          mark;
		int          i;
		start_test("core_writes");
		mark  = ram_log.size();
		bp_on = 1'b1;
		for (i = 0; i < 6; i++) begin
			data_state = lcg_next(data_state);
			r.addr     = data_state[26:0];
			r.be       = data_state[19:16];
			data_state = lcg_next(data_state);
			r.data     = data_state;
			send_core(r);
			expected.push_back(r);
		end
		wait_log(mark + 6);
		bp_on = 1'b0;
		for (i = 0; i < 6 && mark + i < ram_log.size(); i++)
			check_req("core write", expected[i], ram_log[mark + i]);

		// Core locked out while a download owns the channel
		mark          = ram_log.size();
		host.index    = `IDX_BIOS;
		host.download = 1'b1;
		repeat (2) @(negedge clk_1x);
		core_wr_req   = r;
		core_wr_valid = 1'b1;
		repeat (8) begin
			@(posedge clk_1x);
			check_bit("core_wr_ready during download", 1'b0, core_wr_ready);
		end
		@(negedge clk_1x);
		core_wr_valid = 1'b0;
		host.download = 1'b0;
		repeat (3) @(negedge clk_1x);
		check_bit("no RAM write during download", 1'b1, ram_log.size() == mark);
		finish_test();
	endtask

	// ========================================
	// Main sequence
	// ========================================
	initial begin
		clk_1x          = 1'b0;
		rst_n           = 1'b0;
		host            = '0;
		user_reset      = 1'b0;
		img_mounted     = '0;
		img_size        = '0;
		card_load_req   = 1'b0;
		card_save_req   = 1'b0;
		osd_open        = 1'b0;
		autosave_en     = 1'b0;
		core_wr_req     = '0;
		core_wr_valid   = 1'b0;
		bp_on           = 1'b0;
		data_state      = 32'd90;
		media_exp       = '0;
		errors          = 0;
		errors_at_start = 0;
		tests_run       = 0;
		tests_failed    = 0;
		repeat (3) @(negedge clk_1x);
		rst_n = 1'b1;
		@(negedge clk_1x);

		test_reset_state();
		test_bios();
		test_exe();
		test_cd();
		test_cards();
		test_core_writes();

		$display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

	// Hard limit on simulated time
	initial begin
		#400000;
		$display("Simulation time limit reached before the tests finished");
		$display("TB FAILED");
		$finish;
	end

endmodule

// File: design/psx_loader_top.sv
/*
 * Loader top
 * Download handling, media mount tracking and SDRAM write sharing
 */
module psx_loader_top import loader_pkg::*; (
	input  logic          clk_1x,
	input  logic          rst_n,
	input  host_dl_t      host,
	input  logic          user_reset,
	input  logic [2:0]    img_mounted,
	input  img_size_t     img_size,
	input  logic          card_load_req,
	input  logic          card_save_req,
	input  logic          osd_open,
	input  logic          autosave_en,
	input  ram_wr_req_t   core_wr_req,
	input  logic          core_wr_valid,
	output logic          core_wr_ready,
	output ram_wr_req_t   ram_wr_req,
	output logic          ram_wr_valid,
	input  logic          ram_wr_ready,
	output logic          host_wait,
	output media_status_t media,
	output card_cmd_t     card_cmd,
	output logic          core_hold,
	output logic          exe_start
);

	dl_kind_t    dl_kind;
	cd_size_t    dl_cd_size;
	logic        dl_cd_done;
	ram_wr_req_t loader_req;
	logic        loader_valid;
	logic        loader_ready;

	download_tracker u_tracker (
		.clk_1x     (clk_1x),
		.rst_n      (rst_n),
		.host       (host),
		.user_reset (user_reset),
		.dl_kind    (dl_kind),
		.core_hold  (core_hold),
		.exe_start  (exe_start),
		.dl_cd_size (dl_cd_size),
		.dl_cd_done (dl_cd_done)
	);

	download_packer u_packer (
		.clk_1x    (clk_1x),
		.rst_n     (rst_n),
		.host      (host),
		.dl_kind   (dl_kind),
		.wr_req    (loader_req),
		.wr_valid  (loader_valid),
		.wr_ready  (loader_ready),
		.host_wait (host_wait)
	);

	media_mount_ctrl u_mount (
		.clk_1x        (clk_1x),
		.rst_n         (rst_n),
		.img_mounted   (img_mounted),
		.img_size      (img_size),
		.dl_cd_size    (dl_cd_size),
		.dl_cd_done    (dl_cd_done),
		.card_load_req (card_load_req),
		.card_save_req (card_save_req),
		.osd_open      (osd_open),
		.autosave_en   (autosave_en),
		.media         (media),
		.card_cmd      (card_cmd)
	);

	sdram_write_arbiter u_arbiter (
		.clk_1x       (clk_1x),
		.rst_n        (rst_n),
		.dl_kind      (dl_kind),
		.loader_req   (loader_req),
		.loader_valid (loader_valid),
		.loader_ready (loader_ready),
		.core_req     (core_wr_req),
		.core_valid   (core_wr_valid),
		.core_ready   (core_wr_ready),
		.ram_req      (ram_wr_req),
		.ram_valid    (ram_wr_valid),
		.ram_ready    (ram_wr_ready)
	);

endmodule

// File: design/sdram_write_arbiter.sv
/*
 * SDRAM write arbiter
 * Gives the single write channel to the loader during downloads and
 * to the core otherwise, switching only between transfers
 */
module sdram_write_arbiter import loader_pkg::*; (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  dl_kind_t    dl_kind,
	input  ram_wr_req_t loader_req,
	input  logic        loader_valid,
	output logic        loader_ready,
	input  ram_wr_req_t core_req,
	input  logic        core_valid,
	output logic        core_ready,
	output ram_wr_req_t ram_req,
	output logic        ram_valid,
	input  logic        ram_ready
);

	arb_state_t owner;
	arb_state_t want;
	logic       pending;

	assign want = (dl_kind != DL_NONE) ? ARB_LOADER : ARB_CORE;

	// A transfer still open after this edge blocks the switch
	assign pending = ram_valid && !ram_ready;

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n)
			owner <= ARB_CORE;
		else if (!pending)
			owner <= want;
	end

	// ========================================
	// Channel mux
	// ========================================
	always_comb begin
		if (owner == ARB_LOADER) begin
			ram_req   = loader_req;
			ram_valid = loader_valid;
		end else begin
			ram_req   = core_req;
			ram_valid = core_valid;
		end
	end

	assign loader_ready = (owner == ARB_LOADER) && ram_ready;
	assign core_ready   = (owner == ARB_CORE) && ram_ready;

endmodule

// File: design/media_mount_ctrl.sv
/*
 * Media mount control
 * Tracks the CD image and both memory cards, and turns mounts and
 * menu requests into single-cycle memory-card commands
 */
module media_mount_ctrl import loader_pkg::*; (
	input  logic          clk_1x,
	input  logic          rst_n,
	input  logic [2:0]    img_mounted,
	input  img_size_t     img_size,
	input  cd_size_t      dl_cd_size,
	input  logic          dl_cd_done,
	input  logic          card_load_req,
	input  logic          card_save_req,
	input  logic          osd_open,
	input  logic          autosave_en,
	output media_status_t media,
	output card_cmd_t     card_cmd
);

	logic size_nz;
	logic load_q;
	logic save_q;
	logic osd_q;

	assign size_nz = |img_size;

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			media    <= '0;
			card_cmd <= '0;
			load_q   <= 1'b0;
			save_q   <= 1'b0;
			osd_q    <= 1'b0;
		end else begin
			card_cmd <= '0;
			load_q   <= card_load_req;
			save_q   <= card_save_req;
			osd_q    <= osd_open;

			// ========================================
			// CD image
			// ========================================
			if (dl_cd_done) begin
				media.has_cd     <= 1'b1;
				media.cd_from_sd <= 1'b0;
				media.cd_size    <= dl_cd_size;
			end
			// SD mount wins over a download ending the same cycle
			if (img_mounted[0]) begin
				if (size_nz) begin
					media.has_cd     <= 1'b1;
					media.cd_from_sd <= 1'b1;
					media.cd_size    <= img_size[29:0];
				end else begin
					media.has_cd <= 1'b0;
				end
			end

			// ========================================
			// Memory cards
			// ========================================
			if (img_mounted[1]) begin
				media.card1_present <= size_nz;
				card_cmd.card1_load <= size_nz;
			end
			if (img_mounted[2]) begin
				media.card2_present <= size_nz;
				card_cmd.card2_load <= size_nz;
			end

			if (card_load_req && !load_q) begin
				card_cmd.card1_load <= 1'b1;
				card_cmd.card2_load <= 1'b1;
			end
			// Opening the menu triggers a save when autosave is on
			if ((card_save_req && !save_q) || (osd_open && !osd_q && autosave_en))
				card_cmd.save <= 1'b1;
		end
	end

endmodule

// File: design/download_packer.sv
/*
 * Download packer
 * Joins pairs of 16-bit host words into 32-bit RAM write requests
 * placed at the region base, stalling the host until each is taken
 */
`include "loader_consts.svh"

module download_packer import loader_pkg::*; (
	input  logic        clk_1x,
	input  logic        rst_n,
	input  host_dl_t    host,
	input  dl_kind_t    dl_kind,
	output ram_wr_req_t wr_req,
	output logic        wr_valid,
	input  logic        wr_ready,
	output logic        host_wait
);

	ram_addr_t  region_base;
	ram_addr_t  addr_q;
	host_word_t data_lo_q;
	host_word_t data_hi_q;
	logic       accept;
	logic       wr_lo;
	logic       wr_hi;

	always_comb begin
		case (dl_kind)
			DL_BIOS: region_base = `BIOS_BASE;
			DL_EXE:  region_base = `EXE_BASE;
			default: region_base = `CD_BASE;
		endcase
	end

	// Host words only count while a download is active and nothing is queued
	assign accept = host.wr && (dl_kind != DL_NONE) && !wr_valid;
	assign wr_lo  = accept && !host.addr[1];
	assign wr_hi  = accept && host.addr[1];

	// ========================================
	// Request payload
	// ========================================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			data_lo_q <= '0;
			addr_q    <= '0;
			data_hi_q <= '0;
		end else begin
			if (wr_lo) begin
				data_lo_q <= host.data;
				addr_q    <= region_base + host.addr;
			end
			if (wr_hi)
				data_hi_q <= host.data;
		end
	end

	// ========================================
	// Valid handshake
	// ========================================
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			wr_valid <= 1'b0;
		end else begin
			if (wr_hi)
				wr_valid <= 1'b1;
			else if (wr_valid && wr_ready)
				wr_valid <= 1'b0;
		end
	end

	assign wr_req.addr = addr_q;
	assign wr_req.data = {data_hi_q, data_lo_q};
	// Full words only
	assign wr_req.be   = 4'b1111;

	// Host held off for as long as a word is queued
	assign host_wait = wr_valid;

endmodule

// File: design/download_tracker.sv
/*
 * Download tracker
 * Sorts host downloads into BIOS, EXE or CD, holds the core in reset
 * while loading and flags the end of EXE and CD downloads
 */
`include "loader_consts.svh"

module download_tracker import loader_pkg::*; (
	input  logic     clk_1x,
	input  logic     rst_n,
	input  host_dl_t host,
	input  logic     user_reset,
	output dl_kind_t dl_kind,
	output logic     core_hold,
	output logic     exe_start,
	output cd_size_t dl_cd_size,
	output logic     dl_cd_done
);

	dl_kind_t kind_next;
	dl_kind_t kind_prev;
	logic     cd_end;

	// Classify from the index codes
	always_comb begin
		kind_next = DL_NONE;
		if (host.download) begin
			if (host.index == `IDX_BIOS)
				kind_next = DL_BIOS;
			else if (host.index == `IDX_EXE)
				kind_next = DL_EXE;
			else if (host.index[5:0] == `IDX_CD)
				kind_next = DL_CD;
		end
	end

	assign cd_end = (dl_kind == DL_CD) && (kind_next != DL_CD);

	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n) begin
			dl_kind    <= DL_NONE;
			kind_prev  <= DL_NONE;
			exe_start  <= 1'b0;
			dl_cd_done <= 1'b0;
		end else begin
			dl_kind    <= kind_next;
			kind_prev  <= dl_kind;
			// One cycle after the kind has dropped out of EXE
			exe_start  <= (kind_prev == DL_EXE) && (dl_kind != DL_EXE);
			dl_cd_done <= cd_end;
		end
	end

	// Last host address of a CD download is its size
	always_ff @(posedge clk_1x or negedge rst_n) begin
		if (!rst_n)
			dl_cd_size <= '0;
		else if (cd_end)
			dl_cd_size <= cd_size_t'(host.addr);
	end

	assign core_hold = user_reset | (dl_kind != DL_NONE);

endmodule

// File: design/loader_pkg.sv
/*
 * Loader types
 * Vector types, state encodings and bundled buses of the loader
 */
`include "loader_consts.svh"

package loader_pkg;

	typedef logic [`RAM_ADDR_W-1:0] ram_addr_t;
	typedef logic [31:0]            ram_data_t;
	typedef logic [15:0]            host_word_t;
	typedef logic [3:0]             byte_en_t;
	typedef logic [7:0]             dl_index_t;
	typedef logic [63:0]            img_size_t;
	typedef logic [29:0]            cd_size_t;

	typedef enum logic [1:0] {DL_NONE, DL_BIOS, DL_EXE, DL_CD} dl_kind_t;
	typedef enum logic {ARB_CORE, ARB_LOADER} arb_state_t;

	// Host download port
	typedef struct packed {
		logic       download;
		dl_index_t  index;
		ram_addr_t  addr;
		host_word_t data;
		logic       wr;
	} host_dl_t;

	typedef struct packed {
		ram_addr_t addr;
		ram_data_t data;
		byte_en_t  be;
	} ram_wr_req_t;

	typedef struct packed {
		logic     has_cd;
		logic     cd_from_sd;
		cd_size_t cd_size;
		logic     card1_present;
		logic     card2_present;
	} media_status_t;

	// One-cycle memory-card commands
	typedef struct packed {
		logic card1_load;
		logic card2_load;
		logic save;
	} card_cmd_t;

endpackage

// File: design/loader_consts.svh
/*
 * Loader constants
 * RAM region bases, download index codes and address width
 */

`ifndef LOADER_CONSTS_SVH
`define LOADER_CONSTS_SVH

// ========================================
// RAM regions, byte addresses
// ========================================
`define BIOS_BASE   27'h0200000
`define EXE_BASE    27'h0400000
`define CD_BASE     27'h0000000

// ========================================
// Download index codes
// ========================================
`define IDX_BIOS    8'd0
`define IDX_EXE     8'd1
// Matched against the low six index bits only
`define IDX_CD      6'd2

`define RAM_ADDR_W  27

`endif
